// File: source/guitar_config.svh
/* Audio front end widths and ratios */

`ifndef GUITAR_CONFIG_SVH
`define GUITAR_CONFIG_SVH

////////////////////////////////////////
// ADC and oversampling
////////////////////////////////////////

`define GH_ADC_W        12  // Raw conversion code
`define GH_OS_LOW_LOG2  4   // 16x ratio
`define GH_OS_HIGH_LOG2 8   // 256x ratio

// Oversampled widths gain half a bit per doubling of the ratio
`define GH_OS_LOW_W  (`GH_ADC_W + `GH_OS_LOW_LOG2 / 2)
`define GH_OS_HIGH_W (`GH_ADC_W + `GH_OS_HIGH_LOG2 / 2)

////////////////////////////////////////
// Frame RAM and audio output
////////////////////////////////////////

`define GH_FRAME_AW 12  // 4096 words
`define GH_FRAME_DW 16
`define GH_PWM_W    11  // 2048-cycle PWM period

`endif

// File: source/guitar_pkg.sv
/* Front end shared types */

`default_nettype none

`include "guitar_config.svh"

package guitar_pkg;

    // One ADC conversion result, code qualified by eoc
    typedef struct packed {
        logic                 eoc;   // Single-cycle conversion done
        logic [`GH_ADC_W-1:0] code;
    } adc_sample_t;

    // Read request from the spectral reader
    typedef struct packed {
        logic [`GH_FRAME_AW-1:0] addr;
    } frame_read_t;

endpackage

`default_nettype wire

// File: source/oversampler.sv
/* Averaging oversampler */

`timescale 1ns/1ps
`default_nettype none

`include "guitar_config.svh"

module oversampler
    import guitar_pkg::*;
#(
    parameter int LOG2_RATIO = `GH_OS_LOW_LOG2,
    localparam int SHIFT = LOG2_RATIO / 2,
    localparam int OUT_W = `GH_ADC_W + SHIFT
)(
    input  logic             clk_104mhz,
    input  logic             arst_n,
    input  adc_sample_t      adc_in,
    output logic [OUT_W-1:0] oversample,
    output logic             done
);

    // Sum of 2**LOG2_RATIO codes, even ratios only
    localparam int ACC_W = OUT_W + SHIFT;

    logic [LOG2_RATIO-1:0] strobe_cnt;
    logic [ACC_W-1:0]      acc;
    logic [ACC_W-1:0]      sum_next;
    logic                  last_strobe;

    assign sum_next    = acc + ACC_W'(adc_in.code);
    assign last_strobe = adc_in.eoc && (strobe_cnt == '1);  // Nth conversion of the group

    always_ff @(posedge clk_104mhz or negedge arst_n)
    begin
        if (!arst_n)
        begin
            strobe_cnt <= '0;
            acc        <= '0;
            oversample <= '0;
            done       <= 1'b0;
        end
        else
        begin
            done <= last_strobe;
            if (adc_in.eoc)
            begin
                strobe_cnt <= strobe_cnt + 1'b1;  // Wraps back to 0 after the group
                if (last_strobe)
                begin
                    // Divide by sqrt(N) keeps the extra resolution bits
                    oversample <= sum_next[ACC_W-1:SHIFT];
                    acc        <= '0;
                end
                else
                begin
                    acc <= sum_next;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/frame_buffer.sv
/* Sample frame RAM */

`timescale 1ns/1ps
`default_nettype none

`include "guitar_config.svh"

module frame_buffer
    import guitar_pkg::*;
(
    input  logic                    clk_104mhz,
    input  logic                    arst_n,
    input  logic                    wr_strobe,
    input  logic [`GH_FRAME_DW-1:0] wr_data,
    input  frame_read_t             frame_rd,
    output logic [`GH_FRAME_DW-1:0] frame_data,
    output logic [`GH_FRAME_AW-1:0] frame_head
);

    localparam int DEPTH = 1 << `GH_FRAME_AW;

    logic [`GH_FRAME_DW-1:0] mem [0:DEPTH-1];

    ////////////////////////////////////////
    // Write side
    ////////////////////////////////////////

    // Head pointer marks the slot for the next oversampled word
    always_ff @(posedge clk_104mhz or negedge arst_n)
    begin
        if (!arst_n)
        begin
            frame_head <= '0;
        end
        else if (wr_strobe)
        begin
            frame_head <= frame_head + 1'b1;  // Wraps at the end of the frame
        end
    end

    always_ff @(posedge clk_104mhz)
    begin
        if (wr_strobe)
        begin
            mem[frame_head] <= wr_data;
        end
    end

    ////////////////////////////////////////
    // Read side
    ////////////////////////////////////////

    // One cycle latency; a colliding write shows the old word
    always_ff @(posedge clk_104mhz)
    begin
        frame_data <= mem[frame_rd.addr];
    end

endmodule

`default_nettype wire

// File: source/pwm_audio.sv
/* PWM audio output */

`timescale 1ns/1ps
`default_nettype none

`include "guitar_config.svh"

module pwm_audio (
    input  logic                     clk_104mhz,
    input  logic                     arst_n,
    input  logic                     source_fast,
    input  logic [`GH_OS_LOW_W-1:0]  sample_low,
    input  logic [`GH_OS_HIGH_W-1:0] sample_high,
    output logic                     audio_pwm
);

    logic                 src_meta;
    logic                 src_sync;
    logic [`GH_PWM_W-1:0] sample_sel;
    logic [`GH_PWM_W-1:0] pwm_cnt;
    logic [`GH_PWM_W-1:0] level;
    logic [`GH_PWM_W-1:0] level_eff;

    ////////////////////////////////////////
    // Switch synchroniser
    ////////////////////////////////////////

    always_ff @(posedge clk_104mhz or negedge arst_n)
    begin
        if (!arst_n)
        begin
            src_meta <= 1'b0;
            src_sync <= 1'b0;
        end
        else
        begin
            src_meta <= source_fast;
            src_sync <= src_meta;
        end
    end

    // Top 11 bits of whichever stream is selected
    assign sample_sel = src_sync ? sample_low[`GH_OS_LOW_W-1 -: `GH_PWM_W]
                                 : sample_high[`GH_OS_HIGH_W-1 -: `GH_PWM_W];

    ////////////////////////////////////////
    // PWM generator
    ////////////////////////////////////////

    // New level counts from the first cycle of its own period
    assign level_eff = (pwm_cnt == '0) ? sample_sel : level;

    always_ff @(posedge clk_104mhz or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pwm_cnt   <= '0;
            level     <= '0;
            audio_pwm <= 1'b0;
        end
        else
        begin
            pwm_cnt <= pwm_cnt + 1'b1;  // Free running, period 2048
            if (pwm_cnt == '0)
            begin
                level <= sample_sel;
            end
            audio_pwm <= (pwm_cnt < level_eff);  // Registered compare, level high cycles per period
        end
    end

endmodule

`default_nettype wire

// File: source/guitar_frontend.sv
/* Guitar audio sampling front end */

`timescale 1ns/1ps
`default_nettype none

`include "guitar_config.svh"

module guitar_frontend
    import guitar_pkg::*;
(
    input  logic                    clk_104mhz,
    input  logic                    arst_n,
    input  adc_sample_t             adc_in,
    input  logic                    source_fast,
    input  frame_read_t             frame_rd,
    output logic [`GH_FRAME_DW-1:0] frame_data,
    output logic [`GH_FRAME_AW-1:0] frame_head,
    output logic                    audio_pwm
);

    logic [`GH_OS_LOW_W-1:0]  os_low;
    logic                     os_low_done;
    logic [`GH_OS_HIGH_W-1:0] os_high;
    logic                     os_high_done;

    ////////////////////////////////////////
    // Oversamplers
    ////////////////////////////////////////

    // 16x stream for audio
    oversampler #(
        .LOG2_RATIO (`GH_OS_LOW_LOG2)
    ) u_os_low (
        .clk_104mhz (clk_104mhz),
        .arst_n     (arst_n),
        .adc_in     (adc_in),
        .oversample (os_low),
        .done       (os_low_done)
    );

    // 256x stream feeds the frame RAM
    oversampler #(
        .LOG2_RATIO (`GH_OS_HIGH_LOG2)
    ) u_os_high (
        .clk_104mhz (clk_104mhz),
        .arst_n     (arst_n),
        .adc_in     (adc_in),
        .oversample (os_high),
        .done       (os_high_done)
    );

    ////////////////////////////////////////
    // Frame store and audio out
    ////////////////////////////////////////

    frame_buffer u_frame (
        .clk_104mhz (clk_104mhz),
        .arst_n     (arst_n),
        .wr_strobe  (os_high_done),  // One word per 256 conversions
        .wr_data    (os_high),
        .frame_rd   (frame_rd),
        .frame_data (frame_data),
        .frame_head (frame_head)
    );

    pwm_audio u_pwm (
        .clk_104mhz  (clk_104mhz),
        .arst_n      (arst_n),
        .source_fast (source_fast),
        .sample_low  (os_low),
        .sample_high (os_high),
        .audio_pwm   (audio_pwm)
    );

endmodule

`default_nettype wire

// File: bench/guitar_frontend_sva.sv
/* Front end assertions */

`timescale 1ns/1ps
`default_nettype none

`include "guitar_config.svh"

module guitar_frontend_sva (
    input logic                    clk_104mhz,
    input logic                    arst_n,
    input logic                    os_low_done,
    input logic                    os_high_done,
    input logic [`GH_FRAME_AW-1:0] frame_head,
    input logic                    audio_pwm
);

    ////////////////////////////////////////
    // Frame head pointer
    ////////////////////////////////////////

    head_advance: assert property (@(posedge clk_104mhz) disable iff (!arst_n)
        os_high_done |=> frame_head == $past(frame_head) + 1'b1)
        else $error("frame_head did not advance on a 256x result");

    head_hold: assert property (@(posedge clk_104mhz) disable iff (!arst_n)
        !os_high_done |=> $stable(frame_head))
        else $error("frame_head moved without a 256x result");

    // Done pulses are single cycle
    low_done_pulse: assert property (@(posedge clk_104mhz) disable iff (!arst_n)
        os_low_done |=> !os_low_done)
        else $error("16x done lasted two cycles");

    high_done_pulse: assert property (@(posedge clk_104mhz) disable iff (!arst_n)
        os_high_done |=> !os_high_done)
        else $error("256x done lasted two cycles");

    pwm_reset_low: assert property (@(posedge clk_104mhz) !arst_n |-> !audio_pwm)
        else $error("audio_pwm high during reset");

endmodule

bind guitar_frontend guitar_frontend_sva u_sva (
    .clk_104mhz   (clk_104mhz),
    .arst_n       (arst_n),
    .os_low_done  (os_low_done),
    .os_high_done (os_high_done),
    .frame_head   (frame_head),
    .audio_pwm    (audio_pwm)
);

`default_nettype wire

// File: bench/guitar_frontend_tb.sv
/* Front end testbench */

`timescale 1ns/1ps
`default_nettype none

`include "guitar_config.svh"

module guitar_frontend_tb
    import guitar_pkg::*;
();

    // About 1300 conversions of 4 cycles plus 9 PWM periods make roughly 24k cycles
    localparam int TIMEOUT_CYCLES = 60000;

    logic                    clk_104mhz;
    logic                    arst_n;
    adc_sample_t             adc_in;
    logic                    source_fast;
    frame_read_t             frame_rd;
    logic [`GH_FRAME_DW-1:0] frame_data;
    logic [`GH_FRAME_AW-1:0] frame_head;
    logic                    audio_pwm;

    int          errors = 0;
    int          cycle_count = 0;

    guitar_frontend u_guitar_frontend (
        .clk_104mhz  (clk_104mhz),
        .arst_n      (arst_n),
        .adc_in      (adc_in),
        .source_fast (source_fast),
        .frame_rd    (frame_rd),
        .frame_data  (frame_data),
        .frame_head  (frame_head),
        .audio_pwm   (audio_pwm)
    );

    initial
    begin
        clk_104mhz = 1'b0;
        forever
        begin
            #20 clk_104mhz = ~clk_104mhz;
        end
    end

    always @(posedge clk_104mhz)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("Test FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    // One strobe every 4 cycles
    task automatic send_conversion(input logic [`GH_ADC_W-1:0] value);
        @(posedge clk_104mhz);
        adc_in <= '{eoc: 1'b1, code: value};
        @(posedge clk_104mhz);
        adc_in.eoc <= 1'b0;
        repeat (2) @(posedge clk_104mhz);
    endtask

    task automatic apply_reset();
        @(posedge clk_104mhz);
        arst_n <= 1'b0;
        repeat (10) @(posedge clk_104mhz);
        arst_n <= 1'b1;
    endtask

    // Returns on the first high sample of a PWM period
    task automatic wait_rise();
        logic prev;
        prev = 1'b1;
        @(negedge clk_104mhz);
        while (!(audio_pwm && !prev))
        begin
            prev = audio_pwm;
            @(negedge clk_104mhz);
        end
    endtask

    task automatic measure_high(output int high_count);
        wait_rise();
        high_count = 0;
        repeat (2048)
        begin
            if (audio_pwm)
                high_count++;
            @(negedge clk_104mhz);
        end
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    task automatic test_reset_state();
        for (int i = 0; i < 14; i++)
        begin
            if (i == 10)
            begin
                @(posedge clk_104mhz);
                arst_n <= 1'b1;  // Release after 10 cycles
            end
            @(negedge clk_104mhz);
            if (audio_pwm != 1'b0)
            begin
                $display("Fail reset_state: audio_pwm expected 0, actual %0d", audio_pwm);
                errors++;
            end
            if (frame_head != '0)
            begin
                $display("Fail reset_state: frame_head expected 0, actual %0d", frame_head);
                errors++;
            end
        end
    endtask

    task automatic test_partial_group();
        for (int i = 0; i < 255; i++)
            send_conversion(12'($urandom));
        repeat (2) @(posedge clk_104mhz);
        @(negedge clk_104mhz);
        if (frame_head != '0)
        begin
            $display("Fail partial_group: frame_head expected 0, actual %0d", frame_head);
            errors++;
        end
    endtask

    task automatic test_frame_writing();
        logic [19:0]             sums [3];
        logic [`GH_ADC_W-1:0]    value;
        logic [`GH_FRAME_DW-1:0] expected;
        for (int g = 0; g < 3; g++)
        begin
            sums[g] = '0;
            for (int i = 0; i < 256; i++)
            begin
                value   = 12'($urandom);
                sums[g] = sums[g] + 20'(value);
                send_conversion(value);
            end
        end
        repeat (2) @(posedge clk_104mhz);
        @(negedge clk_104mhz);
        if (frame_head != 12'd3)
        begin
            $display("Fail frame_writing: frame_head expected 3, actual %0d", frame_head);
            errors++;
        end
        for (int a = 0; a < 3; a++)
        begin
            @(posedge clk_104mhz);
            frame_rd <= '{addr: 12'(a)};
            @(posedge clk_104mhz);
            @(negedge clk_104mhz);
            expected = 16'(sums[a] >> 4);  // Sum of 256 over sqrt(256)
            if (frame_data != expected)
            begin
                $display("Fail frame_writing: word %0d expected %0d, actual %0d",
                         a, expected, frame_data);
                errors++;
            end
        end
    endtask

    task automatic test_low_rate_audio();
        logic [`GH_ADC_W-1:0] value;
        logic [15:0]          average;
        int                   expected;
        int                   high_count;
        value = 12'(32'd256 + $urandom % 32'd3584);  // Nonzero level keeps a rising edge
        for (int i = 0; i < 256; i++)
            send_conversion(value);
        average  = 16'((256 * int'(value)) >> 4);
        expected = int'(average[15:5]);
        repeat (2) wait_rise();
        measure_high(high_count);
        if (high_count != expected)
        begin
            $display("Fail low_rate_audio: expected %0d, actual %0d", expected, high_count);
            errors++;
        end
    endtask

    task automatic test_fast_rate_audio();
        logic [`GH_ADC_W-1:0] value;
        logic [13:0]          average;
        int                   expected;
        int                   high_count;
        @(posedge clk_104mhz);
        source_fast <= 1'b1;
        value = 12'(32'd256 + $urandom % 32'd3584);
        for (int i = 0; i < 32; i++)
            send_conversion(value);
        average  = 14'((16 * int'(value)) >> 2);
        expected = int'(average[13:3]);
        repeat (3) wait_rise();
        measure_high(high_count);
        if (high_count != expected)
        begin
            $display("Fail fast_rate_audio: expected %0d, actual %0d", expected, high_count);
            errors++;
        end
    endtask

    initial
    begin
        arst_n      = 1'b0;
        adc_in      = '0;
        source_fast = 1'b0;
        frame_rd    = '0;
        void'($urandom(32'h17ac));

        test_reset_state();
        test_partial_group();
        apply_reset();  // Realign both groups for the frame test
        test_frame_writing();
        test_low_rate_audio();
        test_fast_rate_audio();

        $display("Errors: %0d", errors);
        if (errors == 0)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+source
source/guitar_pkg.sv
source/oversampler.sv
source/frame_buffer.sv
source/pwm_audio.sv
source/guitar_frontend.sv
bench/guitar_frontend_sva.sv
bench/guitar_frontend_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := guitar_frontend_tb
FILELIST  := list.f
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "^Test OK$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
